//--- compile.f
+incdir+hw
hw/fpseq_pkg.sv
hw/fpseq_decoder.sv
hw/fpseq_fpr_file.sv
hw/fpseq_scoreboard.sv
hw/fpseq_dispatch.sv
hw/fpseq_retire.sv
hw/fpu_sequencer.sv
tests/fpseq_properties.sv
tests/tb_fpu_sequencer.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fpu_sequencer
FLIST     = compile.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tests/tb_fpu_sequencer.sv
//////////////////////////////////////////////////
// Random testbench for the FP sequencer
// Emulated vector unit returns the XOR of the operands
// Forwarded IDs of fd writers carry fd in their low five bits
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module tb_fpu_sequencer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RAND   = 300;
  localparam int NUM_INSTR  = 3 * `FPSEQ_NUM_FPR + NUM_RAND;
  localparam int MAX_CYCLES = 40 * NUM_INSTR + 200;

  logic clk;
  logic arst_n;
  fpseq_pkg::issue_req_t  issue_req;
  logic                   issue_valid;
  logic                   issue_ready;
  fpseq_pkg::issue_resp_t issue_resp;
  fpseq_pkg::result_t     result;
  logic                   result_valid;
  logic                   result_ready;
  fpseq_pkg::issue_req_t  vec_req;
  logic                   vec_valid;
  logic                   vec_ready;
  logic                   vec_accept;
  fpseq_pkg::result_t     vec_result;
  logic                   vec_result_valid;
  logic                   vec_result_ready;

  // Reference model state
  logic [31:0]             fpr_m [`FPSEQ_NUM_FPR];
  logic [31:0]             pend_m;
  fpseq_pkg::result_t      mv_exp [$];
  fpseq_pkg::result_t      vq [$];
  int                      vq_due [$];
  fpseq_pkg::issue_req_t   drv_req;
  logic                    drv_valid;
  fpseq_pkg::decode_t      cur_dec;
  logic                    cur_done;
  logic                    vres_done;
  logic                    hold_pend;
  fpseq_pkg::result_t      held_res;
  int                      cycles;
  int                      errors;
  int                      checks;

  fpu_sequencer DUT (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .issue_req_i       (issue_req),
    .issue_valid_i     (issue_valid),
    .issue_ready_o     (issue_ready),
    .issue_resp_o      (issue_resp),
    .result_o          (result),
    .result_valid_o    (result_valid),
    .result_ready_i    (result_ready),
    .vec_req_o         (vec_req),
    .vec_valid_o       (vec_valid),
    .vec_ready_i       (vec_ready),
    .vec_accept_i      (vec_accept),
    .vec_result_i      (vec_result),
    .vec_result_valid_i(vec_result_valid),
    .vec_result_ready_o(vec_result_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles, errors so far %0d", MAX_CYCLES, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic report(input string msg);
    errors++;
    $display("[%0t] %s", $time, msg);
  endtask

  function automatic logic has_hazard(input fpseq_pkg::decode_t d);
    return (d.use_fs1 && pend_m[d.fs1]) || (d.use_fs2 && pend_m[d.fs2]) ||
           (d.use_fs3 && pend_m[d.fs3]) || (d.use_fd && pend_m[d.fd]);
  endfunction

  ////////////////////////////////////////////////////
  // One clock cycle: drive, sample, check, update
  ////////////////////////////////////////////////////

  task automatic cycle_step();
    fpseq_pkg::issue_req_t  exp_req;
    fpseq_pkg::issue_resp_t exp_resp;
    fpseq_pkg::result_t     mv_res;
    logic                   hz;
    logic                   is_local;
    logic                   do_set;
    logic                   do_wr;
    logic                   do_mv;
    @(negedge clk);
    issue_req   = drv_req;
    issue_valid = drv_valid;
    if (vres_done) begin
      vec_result_valid = 1'b0;
      vres_done        = 1'b0;
    end
    if (!vec_result_valid && vq.size() > 0 && vq_due[0] <= cycles) begin
      vec_result       = vq[0];
      vec_result_valid = 1'b1;
    end
    vec_ready    = ($urandom_range(9, 0) < 7);
    vec_accept   = ($urandom_range(9, 0) < 9);
    result_ready = ($urandom_range(9, 0) < 7);
    // Sample just before the rising edge
    #4;
    do_set = 1'b0;
    do_wr  = 1'b0;
    do_mv  = 1'b0;
    mv_res = '0;

    if (issue_valid) begin
      is_local = cur_dec.is_move || cur_dec.illegal;
      hz       = has_hazard(cur_dec);
      checks++;
      if (hz && (vec_valid || issue_ready))
        report("Instruction issued while one of its registers was pending");
      if (is_local && vec_valid)
        report("Local instruction was forwarded to the vector unit");
      if (is_local && !hz && !(cur_dec.use_rd && mv_exp.size() > 0) && !issue_ready)
        report("Local instruction was not accepted although nothing stalled it");
      if (!is_local && !hz && !vec_valid)
        report("Instruction without hazard was not forwarded");
      if (!is_local && issue_ready !== (!hz && vec_ready)) begin
        errors++;
        $display("Error: issue_ready_o got %h expected %h", issue_ready, !hz && vec_ready);
      end
      if (!is_local && vec_valid && vec_ready) begin
        exp_req = drv_req;
        if (cur_dec.use_fs1) exp_req.rs[0] = fpr_m[cur_dec.fs1];
        if (cur_dec.use_fs2) exp_req.rs[1] = fpr_m[cur_dec.fs2];
        if (cur_dec.use_fs3) exp_req.rs[2] = fpr_m[cur_dec.fs3];
        exp_req.id[`FPSEQ_FPR_FLAG] = cur_dec.use_fd;
        if (vec_req !== exp_req) begin
          errors++;
          $display("Error: vec_req_o got %h expected %h", vec_req, exp_req);
        end
        exp_resp = '{vec_accept, 1'b0, 1'b0};
        if (issue_resp !== exp_resp) begin
          errors++;
          $display("Error: issue_resp_o got %h expected %h", issue_resp, exp_resp);
        end
        if (vec_accept) begin
          vq.push_back('{vec_req.id, vec_req.rs[0] ^ vec_req.rs[1] ^ vec_req.rs[2], 1'b1});
          vq_due.push_back(cycles + int'($urandom_range(6, 1)));
          do_set = cur_dec.use_fd;
        end
        cur_done = 1'b1;
      end
      if (is_local && issue_ready) begin
        exp_resp = '{cur_dec.use_rd, cur_dec.use_rd, cur_dec.illegal};
        if (issue_resp !== exp_resp) begin
          errors++;
          $display("Error: issue_resp_o got %h expected %h", issue_resp, exp_resp);
        end
        do_wr    = cur_dec.use_fd;
        do_mv    = cur_dec.use_rd;
        mv_res   = '{drv_req.id, fpr_m[cur_dec.fs1], 1'b1};
        cur_done = 1'b1;
      end
    end

    // Result routing
    if (vec_result_valid && vec_result.id[`FPSEQ_FPR_FLAG] && !vec_result_ready)
      report("Vector result for the FPR was not taken at once");
    if (vec_result_valid && !vec_result.id[`FPSEQ_FPR_FLAG] && vec_result_ready) begin
      checks++;
      if (!(result_valid && result_ready) || result !== vec_result) begin
        errors++;
        $display("Error: result_o got %h expected %h", result, vec_result);
      end
    end else if (result_valid && result_ready) begin
      checks++;
      if (mv_exp.size() == 0) begin
        report("Move result appeared with none outstanding");
      end else begin
        if (result !== mv_exp[0]) begin
          errors++;
          $display("Error: result_o got %h expected %h", result, mv_exp[0]);
        end
        void'(mv_exp.pop_front());
      end
    end
    if (vec_result_valid && vec_result_ready) begin
      if (vec_result.id[`FPSEQ_FPR_FLAG]) begin
        pend_m[vec_result.id[4:0]] = 1'b0;
        fpr_m[vec_result.id[4:0]]  = vec_result.data;
      end
      void'(vq.pop_front());
      void'(vq_due.pop_front());
      vres_done = 1'b1;
    end

    // Back-pressure must freeze the result
    if (hold_pend && (!result_valid || result !== held_res)) begin
      errors++;
      $display("Error: result_o got %h expected held %h", result, held_res);
    end
    hold_pend = result_valid && !result_ready;
    held_res  = result;

    if (do_set) pend_m[cur_dec.fd] = 1'b1;
    if (do_wr) fpr_m[cur_dec.fd] = drv_req.rs[0];
    if (do_mv) mv_exp.push_back(mv_res);
  endtask

  task automatic issue_instr(input fpseq_pkg::issue_req_t req, input fpseq_pkg::decode_t d);
    drv_req   = req;
    drv_valid = 1'b1;
    cur_dec   = d;
    cur_done  = 1'b0;
    while (!cur_done) cycle_step();
    drv_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // Instruction builder with expected register use
  ////////////////////////////////////////////////////

  task automatic build_instr(input int kind, input logic [4:0] fd, input logic [4:0] fs1,
                             output fpseq_pkg::issue_req_t req, output fpseq_pkg::decode_t d);
    logic [4:0] fs2;
    logic [4:0] fs3;
    logic [1:0] sel;
    fs2 = 5'($urandom());
    fs3 = 5'($urandom());
    sel = 2'($urandom());
    d   = '0;
    req = '0;
    req.rs[0] = $urandom();
    req.rs[1] = $urandom();
    req.rs[2] = $urandom();
    req.id    = 6'($urandom());
    case (kind)
      0: begin
        req.instr = {7'b1111000, 5'd0, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
        d.use_fd  = 1'b1;
        d.is_move = 1'b1;
      end
      1: begin
        req.instr = {7'b1110000, 5'd0, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
        d.use_fs1 = 1'b1;
        d.use_rd  = 1'b1;
        d.is_move = 1'b1;
      end
      2: begin
        req.instr = {7'b0000000, fs2, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
        d.use_fs1 = 1'b1;
        d.use_fs2 = 1'b1;
        d.use_fd  = 1'b1;
      end
      3: begin
        req.instr = {7'b1010000, fs2, fs1, 3'b010, fd, `FPSEQ_OPC_OPFP};
        d.use_fs1 = 1'b1;
        d.use_fs2 = 1'b1;
      end
      4: begin
        req.instr = {7'b1101000, fs2, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
        d.use_fs2 = 1'b1;
        d.use_fd  = 1'b1;
      end
      5: begin
        req.instr = {fs3, 2'b00, fs2, fs1, 3'b000, fd, 3'b100, sel, 2'b11};
        d.use_fs1 = 1'b1;
        d.use_fs2 = 1'b1;
        d.use_fs3 = 1'b1;
        d.use_fd  = 1'b1;
      end
      6: begin
        req.instr = {6'($urandom()), 1'b1, fs2, fs1, 3'b101, fd, `FPSEQ_OPC_OPV};
        d.use_fs1 = 1'b1;
      end
      default: begin
        // Divide, sqrt, double add, double fused
        case (sel)
          2'd0: req.instr = {7'b0001100, fs2, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
          2'd1: req.instr = {7'b0101100, 5'd0, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
          2'd2: req.instr = {7'b0000001, fs2, fs1, 3'b000, fd, `FPSEQ_OPC_OPFP};
          default: req.instr = {fs3, 2'b01, fs2, fs1, 3'b000, fd, `FPSEQ_OPC_FMADD};
        endcase
        d.illegal = 1'b1;
      end
    endcase
    if (d.use_fd && !d.is_move) req.id = {1'b0, fd};
    d.fd  = fd;
    d.fs1 = fs1;
    d.fs2 = fs2;
    d.fs3 = fs3;
  endtask

  initial begin
    fpseq_pkg::issue_req_t req;
    fpseq_pkg::decode_t    d;
    void'($urandom(65));
    arst_n           = 1'b0;
    issue_req        = '0;
    issue_valid      = 1'b0;
    result_ready     = 1'b0;
    vec_ready        = 1'b0;
    vec_accept       = 1'b0;
    vec_result       = '0;
    vec_result_valid = 1'b0;
    drv_req          = '0;
    drv_valid        = 1'b0;
    cur_dec          = '0;
    cur_done         = 1'b0;
    vres_done        = 1'b0;
    hold_pend        = 1'b0;
    held_res         = '0;
    pend_m           = '0;
    cycles           = 0;
    errors           = 0;
    checks           = 0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;

    // Fill every register, then read each back
    for (int r = 0; r < `FPSEQ_NUM_FPR; r++) begin
      build_instr(0, 5'(r), 5'(r), req, d);
      issue_instr(req, d);
    end
    for (int r = 0; r < `FPSEQ_NUM_FPR; r++) begin
      build_instr(1, 5'($urandom()), 5'(r), req, d);
      issue_instr(req, d);
    end
    for (int i = 0; i < NUM_RAND; i++) begin
      build_instr(int'($urandom_range(7, 0)), 5'($urandom()), 5'($urandom()), req, d);
      issue_instr(req, d);
    end
    // Read back what the vector results left
    for (int r = 0; r < `FPSEQ_NUM_FPR; r++) begin
      build_instr(1, 5'($urandom()), 5'(r), req, d);
      issue_instr(req, d);
    end
    while (vq.size() > 0 || mv_exp.size() > 0 || vec_result_valid) cycle_step();

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tests/fpseq_properties.sv
//////////////////////////////////////////////////
// Handshake assertions bound into the FP sequencer
// Stability holds only while reset is released
//////////////////////////////////////////////////

module fpseq_properties (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input fpseq_pkg::result_t     result_o,
  input logic                   result_valid_o,
  input logic                   result_ready_i,
  input fpseq_pkg::issue_req_t  vec_req_o,
  input logic                   vec_valid_o,
  input logic                   vec_ready_i,
  input logic                   issue_ready_o,
  input fpseq_pkg::issue_resp_t issue_resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Core result holds until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
    else $error("result_o changed before it was taken");

  // Forwarded request holds until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vec_valid_o && !vec_ready_i |=> vec_valid_o && $stable(vec_req_o))
    else $error("vec_req_o changed before it was taken");

  assert property (@(posedge clk_i) !arst_n_i |-> !result_valid_o)
    else $error("result_valid_o high during reset");

  // A forwarded issue never carries a local response
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vec_valid_o && issue_ready_o |-> !issue_resp_o.exc && !issue_resp_o.writeback)
    else $error("Local response seen on a forwarded issue");

endmodule

bind fpu_sequencer fpseq_properties u_props (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .result_o      (result_o),
  .result_valid_o(result_valid_o),
  .result_ready_i(result_ready_i),
  .vec_req_o     (vec_req_o),
  .vec_valid_o   (vec_valid_o),
  .vec_ready_i   (vec_ready_i),
  .issue_ready_o (issue_ready_o),
  .issue_resp_o  (issue_resp_o)
);

//--- hw/fpu_sequencer.sv
//////////////////////////////////////////////////
// Scalar FP sequencer between core and vector unit
// All handshakes are valid/ready, issue is combinational
// No FP load/store, single precision only
//////////////////////////////////////////////////

module fpu_sequencer (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Core issue and result
  input  fpseq_pkg::issue_req_t  issue_req_i,
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  output fpseq_pkg::issue_resp_t issue_resp_o,
  output fpseq_pkg::result_t     result_o,
  output logic                   result_valid_o,
  input  logic                   result_ready_i,
  // Vector unit issue and result
  output fpseq_pkg::issue_req_t  vec_req_o,
  output logic                   vec_valid_o,
  input  logic                   vec_ready_i,
  input  logic                   vec_accept_i,
  input  fpseq_pkg::result_t     vec_result_i,
  input  logic                   vec_result_valid_i,
  output logic                   vec_result_ready_o
);

  fpseq_pkg::decode_t        dec;
  fpseq_pkg::fp_data_t [2:0] fpr_rdata;
  fpseq_pkg::fpr_wr_t        ret_wr;
  fpseq_pkg::fpr_wr_t        mv_wr;
  logic                      hazard;
  logic                      sb_set;
  logic                      mv_take;
  logic                      move_full;

  fpseq_decoder u_decoder (
    .issue_req_i  (issue_req_i),
    .issue_valid_i(issue_valid_i),
    .dec_o        (dec)
  );

  fpseq_fpr_file u_fpr (
    .clk_i  (clk_i),
    .raddr_i({dec.fs3, dec.fs2, dec.fs1}),
    .rdata_o(fpr_rdata),
    .wr_i   ({mv_wr, ret_wr})
  );

  fpseq_scoreboard u_sb (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .dec_i   (dec),
    .set_i   (sb_set),
    .clr_i   (ret_wr),
    .hazard_o(hazard)
  );

  fpseq_dispatch u_dispatch (
    .issue_req_i  (issue_req_i),
    .issue_valid_i(issue_valid_i),
    .dec_i        (dec),
    .hazard_i     (hazard),
    .move_full_i  (move_full),
    .rdata_i      (fpr_rdata),
    .vec_ready_i  (vec_ready_i),
    .vec_accept_i (vec_accept_i),
    .issue_ready_o(issue_ready_o),
    .issue_resp_o (issue_resp_o),
    .vec_req_o    (vec_req_o),
    .vec_valid_o  (vec_valid_o),
    .sb_set_o     (sb_set),
    .mv_wr_o      (mv_wr),
    .mv_take_o    (mv_take)
  );

  fpseq_retire u_retire (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .issue_req_i       (issue_req_i),
    .mv_take_i         (mv_take),
    .rdata0_i          (fpr_rdata[0]),
    .vec_result_i      (vec_result_i),
    .vec_result_valid_i(vec_result_valid_i),
    .result_ready_i    (result_ready_i),
    .vec_result_ready_o(vec_result_ready_o),
    .result_o          (result_o),
    .result_valid_o    (result_valid_o),
    .fpr_wr_o          (ret_wr),
    .move_full_o       (move_full)
  );

endmodule

//--- hw/fpseq_retire.sv
//////////////////////////////////////////////////
// Result routing and the move result register
// Vector results to the core go before move results
// A move result already shown holds until taken
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module fpseq_retire (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  fpseq_pkg::issue_req_t issue_req_i,
  input  logic                  mv_take_i,
  input  fpseq_pkg::fp_data_t   rdata0_i,
  input  fpseq_pkg::result_t    vec_result_i,
  input  logic                  vec_result_valid_i,
  input  logic                  result_ready_i,
  output logic                  vec_result_ready_o,
  output fpseq_pkg::result_t    result_o,
  output logic                  result_valid_o,
  output fpseq_pkg::fpr_wr_t    fpr_wr_o,
  output logic                  move_full_o
);

  fpseq_pkg::result_t mv_q;
  logic               mv_valid_q;
  logic               mv_hold_q;
  logic               to_fpr;
  logic               sel_move;
  logic               mv_pop;

  assign to_fpr   = vec_result_valid_i && vec_result_i.id[`FPSEQ_FPR_FLAG];
  // Once presented, the move result keeps result_o until taken
  assign sel_move = mv_valid_q && (mv_hold_q || !vec_result_valid_i);
  assign mv_pop   = sel_move && result_ready_i;

  ////////////////////////////////////////////////////
  // Routing
  ////////////////////////////////////////////////////

  always_comb begin
    result_o           = '0;
    result_valid_o     = 1'b0;
    // FPR results go straight to the register file
    vec_result_ready_o = to_fpr;

    if (sel_move) begin
      result_o       = mv_q;
      result_valid_o = 1'b1;
    end else if (vec_result_valid_i && !to_fpr) begin
      result_o           = vec_result_i;
      result_valid_o     = 1'b1;
      vec_result_ready_o = result_ready_i;
    end
  end

  assign fpr_wr_o.we   = to_fpr;
  assign fpr_wr_o.addr = vec_result_i.id[`FPSEQ_FPR_FLAG-1:0];
  assign fpr_wr_o.data = vec_result_i.data;

  ////////////////////////////////////////////////////
  // Move result register
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mv_valid_q <= 1'b0;
      mv_hold_q  <= 1'b0;
    end else begin
      if (mv_take_i) begin
        mv_valid_q <= 1'b1;
      end else if (mv_pop) begin
        mv_valid_q <= 1'b0;
      end
      mv_hold_q <= sel_move && !result_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mv_take_i) begin
      mv_q.id   <= issue_req_i.id;
      mv_q.data <= rdata0_i;
      mv_q.we   <= 1'b1;
    end
  end

  assign move_full_o = mv_valid_q;

endmodule

//--- hw/fpseq_dispatch.sv
//////////////////////////////////////////////////
// Issue handshake and operand substitution
// Moves and illegal encodings are answered locally
// Everything else is forwarded to the vector unit
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module fpseq_dispatch (
  input  fpseq_pkg::issue_req_t       issue_req_i,
  input  logic                        issue_valid_i,
  input  fpseq_pkg::decode_t          dec_i,
  input  logic                        hazard_i,
  input  logic                        move_full_i,
  input  fpseq_pkg::fp_data_t  [2:0]  rdata_i,
  input  logic                        vec_ready_i,
  input  logic                        vec_accept_i,
  output logic                        issue_ready_o,
  output fpseq_pkg::issue_resp_t      issue_resp_o,
  output fpseq_pkg::issue_req_t       vec_req_o,
  output logic                        vec_valid_o,
  output logic                        sb_set_o,
  output fpseq_pkg::fpr_wr_t          mv_wr_o,
  output logic                        mv_take_o
);

  logic is_local;
  logic stall;
  logic fire;

  assign is_local = dec_i.is_move || dec_i.illegal;
  // FMV.X.W waits for room in the move register
  assign stall    = hazard_i || (dec_i.is_move && dec_i.use_rd && move_full_i);

  assign vec_valid_o   = issue_valid_i && !stall && !is_local;
  assign issue_ready_o = issue_valid_i && !stall && (is_local || vec_ready_i);
  assign fire          = issue_valid_i && issue_ready_o;

  ////////////////////////////////////////////////////
  // Forwarded request
  ////////////////////////////////////////////////////

  always_comb begin
    vec_req_o = issue_req_i;
    if (dec_i.use_fs1) vec_req_o.rs[0] = rdata_i[0];
    if (dec_i.use_fs2) vec_req_o.rs[1] = rdata_i[1];
    if (dec_i.use_fs3) vec_req_o.rs[2] = rdata_i[2];
    // Result comes back to the FPR when fd is written
    vec_req_o.id[`FPSEQ_FPR_FLAG] = dec_i.use_fd;
  end

  always_comb begin
    if (is_local) begin
      issue_resp_o.accept    = dec_i.use_rd;
      issue_resp_o.writeback = dec_i.use_rd;
      issue_resp_o.exc       = dec_i.illegal;
    end else begin
      issue_resp_o.accept    = vec_accept_i;
      issue_resp_o.writeback = 1'b0;
      issue_resp_o.exc       = 1'b0;
    end
  end

  ////////////////////////////////////////////////////
  // Scoreboard and local moves
  ////////////////////////////////////////////////////

  assign sb_set_o = fire && !is_local && dec_i.use_fd && vec_accept_i;

  // FMV.W.X writes rs[0] straight into fd
  assign mv_wr_o.we   = fire && dec_i.is_move && dec_i.use_fd;
  assign mv_wr_o.addr = dec_i.fd;
  assign mv_wr_o.data = issue_req_i.rs[0];

  assign mv_take_o = fire && dec_i.is_move && dec_i.use_rd;

endmodule

//--- hw/fpseq_scoreboard.sv
//////////////////////////////////////////////////
// Pending-write tracking for FP registers
// A set and clear on one index in a cycle keeps the bit
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module fpseq_scoreboard (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  fpseq_pkg::decode_t dec_i,
  input  logic               set_i,
  input  fpseq_pkg::fpr_wr_t clr_i,
  output logic               hazard_o
);

  logic [`FPSEQ_NUM_FPR-1:0] pend_q;
  logic [`FPSEQ_NUM_FPR-1:0] pend_d;

  always_comb begin
    pend_d = pend_q;
    if (clr_i.we) begin
      pend_d[clr_i.addr] = 1'b0;
    end
    // Set after clear so a new writer wins
    if (set_i) begin
      pend_d[dec_i.fd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  // Any used operand or destination still in flight
  assign hazard_o = (dec_i.use_fs1 && pend_q[dec_i.fs1]) ||
                    (dec_i.use_fs2 && pend_q[dec_i.fs2]) ||
                    (dec_i.use_fs3 && pend_q[dec_i.fs3]) ||
                    (dec_i.use_fd  && pend_q[dec_i.fd]);

endmodule

//--- hw/fpseq_fpr_file.sv
//////////////////////////////////////////////////
// FP register file, three reads and two writes
// Writes land at the edge, reads see them next cycle
// Ports must not write the same address together
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module fpseq_fpr_file (
  input  logic                       clk_i,
  input  fpseq_pkg::fpr_addr_t [2:0] raddr_i,
  output fpseq_pkg::fp_data_t  [2:0] rdata_o,
  input  fpseq_pkg::fpr_wr_t   [1:0] wr_i
);

  localparam int unsigned NrReadPorts  = 3;
  localparam int unsigned NrWritePorts = 2;

  fpseq_pkg::fp_data_t regs_q [`FPSEQ_NUM_FPR];

  // Storage only, contents are undefined after reset
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NrWritePorts; p++) begin
      if (wr_i[p].we) begin
        regs_q[wr_i[p].addr] <= wr_i[p].data;
      end
    end
  end

  for (genvar r = 0; r < NrReadPorts; r++) begin : gen_rd
    assign rdata_o[r] = regs_q[raddr_i[r]];
  end

endmodule

//--- hw/fpseq_decoder.sv
//////////////////////////////////////////////////
// Instruction classifier for the FP sequencer
// Double format, divide and sqrt are flagged illegal
// Unknown opcodes decode to no FP register use
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

module fpseq_decoder (
  input  fpseq_pkg::issue_req_t issue_req_i,
  input  logic                  issue_valid_i,
  output fpseq_pkg::decode_t    dec_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [1:0] fmt;

  assign opcode = issue_req_i.instr[6:0];
  assign funct7 = issue_req_i.instr[`FPSEQ_F7_LSB +: 7];
  assign funct3 = issue_req_i.instr[`FPSEQ_F3_LSB +: 3];
  assign fmt    = issue_req_i.instr[`FPSEQ_FMT_LSB +: 2];

  always_comb begin
    dec_o     = '0;
    // Register indices sit at fixed positions
    dec_o.fd  = issue_req_i.instr[`FPSEQ_RD_LSB +: 5];
    dec_o.fs1 = issue_req_i.instr[`FPSEQ_RS1_LSB +: 5];
    dec_o.fs2 = issue_req_i.instr[`FPSEQ_RS2_LSB +: 5];
    dec_o.fs3 = issue_req_i.instr[`FPSEQ_RS3_LSB +: 5];

    if (issue_valid_i) begin
      if (opcode == `FPSEQ_OPC_OPFP) begin
        case (funct7)
          `FPSEQ_F7_FMVXW: begin
            if (funct3 == 3'b000) begin
              // FMV.X.W
              dec_o.use_rd  = 1'b1;
              dec_o.use_fs1 = 1'b1;
              dec_o.is_move = 1'b1;
            end else begin
              // FCLASS reads fs1 only
              dec_o.use_fs1 = 1'b1;
            end
          end
          `FPSEQ_F7_FMVWX: begin
            dec_o.use_fd  = 1'b1;
            dec_o.is_move = 1'b1;
          end
          `FPSEQ_F7_FDIV,
          `FPSEQ_F7_FSQRT: dec_o.illegal = 1'b1;
          default: begin
            if (fmt == `FPSEQ_FMT_D) begin
              dec_o.illegal = 1'b1;
            end else if (fmt == `FPSEQ_FMT_S) begin
              dec_o.use_fs1 = funct7 != `FPSEQ_F7_FCVTSW;
              dec_o.use_fs2 = 1'b1;
              dec_o.use_fd  = !(funct7 inside {`FPSEQ_F7_FCMP, `FPSEQ_F7_FCVTWS});
            end
          end
        endcase
      end else if ((opcode & `FPSEQ_OPC_FMA_MASK) == `FPSEQ_OPC_FMADD) begin
        // Fused multiply-add family
        if (fmt == `FPSEQ_FMT_D) begin
          dec_o.illegal = 1'b1;
        end else if (fmt == `FPSEQ_FMT_S) begin
          dec_o.use_fs1 = 1'b1;
          dec_o.use_fs2 = 1'b1;
          dec_o.use_fs3 = 1'b1;
          dec_o.use_fd  = 1'b1;
        end
      end else if (opcode == `FPSEQ_OPC_OPV && funct3 == `FPSEQ_F3_OPFVF) begin
        // Vector op with FP scalar in fs1
        dec_o.use_fs1 = 1'b1;
      end
    end
  end

endmodule

//--- hw/fpseq_pkg.sv
//////////////////////////////////////////////////
// Types shared by the FP sequencer blocks
// Widths come from the defines header
//////////////////////////////////////////////////

`include "fpseq_defs.svh"

package fpseq_pkg;

  typedef logic [$clog2(`FPSEQ_NUM_FPR)-1:0] fpr_addr_t;
  typedef logic [`FPSEQ_FLEN-1:0]            fp_data_t;

  // Instruction offered by the core, 134 bits
  typedef struct packed {
    logic [31:0]            instr;
    logic [2:0][31:0]       rs;
    logic [`FPSEQ_ID_W-1:0] id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic exc;
  } issue_resp_t;

  // Result towards the core or back from the vector unit
  typedef struct packed {
    logic [`FPSEQ_ID_W-1:0] id;
    logic [31:0]            data;
    logic                   we;
  } result_t;

  typedef struct packed {
    logic      use_fs1;
    logic      use_fs2;
    logic      use_fs3;
    logic      use_fd;
    logic      use_rd;
    logic      is_move;
    logic      illegal;
    fpr_addr_t fd;
    fpr_addr_t fs1;
    fpr_addr_t fs2;
    fpr_addr_t fs3;
  } decode_t;

  typedef struct packed {
    logic      we;
    fpr_addr_t addr;
    fp_data_t  data;
  } fpr_wr_t;

endpackage

//--- hw/fpseq_defs.svh
//////////////////////////////////////////////////
// Shared constants for the FP sequencer
// Single precision only, FLEN is fixed at 32
// ID bit 5 marks results that target the FPR
//////////////////////////////////////////////////

`ifndef FPSEQ_DEFS_SVH
`define FPSEQ_DEFS_SVH

`define FPSEQ_NUM_FPR       32
`define FPSEQ_FLEN          32
`define FPSEQ_ID_W          6
`define FPSEQ_FPR_FLAG      5

// Register field positions in the instruction word
`define FPSEQ_RD_LSB        7
`define FPSEQ_F3_LSB        12
`define FPSEQ_RS1_LSB       15
`define FPSEQ_RS2_LSB       20
`define FPSEQ_FMT_LSB       25
`define FPSEQ_F7_LSB        25
`define FPSEQ_RS3_LSB       27

// Major opcodes; fused forms vary in bits 3:2
`define FPSEQ_OPC_OPFP      7'b1010011
`define FPSEQ_OPC_FMADD     7'b1000011
`define FPSEQ_OPC_FMA_MASK  7'b1110011
`define FPSEQ_OPC_OPV       7'b1010111

// OP-FP funct7 codes (single format)
`define FPSEQ_F7_FMVXW      7'b1110000
`define FPSEQ_F7_FMVWX      7'b1111000
`define FPSEQ_F7_FDIV       7'b0001100
`define FPSEQ_F7_FSQRT      7'b0101100
`define FPSEQ_F7_FCVTSW     7'b1101000
`define FPSEQ_F7_FCVTWS     7'b1100000
`define FPSEQ_F7_FCMP       7'b1010000

`define FPSEQ_FMT_S         2'b00
`define FPSEQ_FMT_D         2'b01
`define FPSEQ_F3_OPFVF      3'b101

`endif
